//--- logic/dbg_pkg.sv
/*
  Debug module definitions
  TAP command frame layout, burst opcodes, counter widths and the
  control and status bundles passed between burst FSM and datapath
*/
package dbg_pkg;

  // TAP data register, newest bit shifted in at the top
  typedef logic [52:0] dr_word_t;

  // Command frame fields
  localparam int FLAG_BIT      = 52;  // 0 = command for this module
  localparam int OP_MSB        = 51;
  localparam int OP_LSB        = 48;
  localparam int ADDR_MSB      = 47;
  localparam int ADDR_LSB      = 16;
  localparam int CNT_MSB       = 15;
  localparam int CNT_LSB       = 0;
  localparam int ERR_CLEAR_BIT = 46;  // Clear bit inside an IREG_WR frame

  typedef enum logic [3:0] {
    BWRITE8  = 4'd1,
    BWRITE16 = 4'd2,
    BWRITE32 = 4'd3,
    BREAD8   = 4'd5,
    BREAD16  = 4'd6,
    BREAD32  = 4'd7,
    IREG_WR  = 4'd9
  } dbg_op_e;

  typedef logic [15:0] word_cnt_t;    // Words left in a burst
  typedef logic [5:0]  bit_cnt_t;     // Up to 32 CRC bits
  typedef logic [2:0]  size_bytes_t;  // 1, 2 or 4

  // TDO source
  typedef enum logic [1:0] {STATUS, DATA, CRC_MATCH, CRC_OUT} tdo_sel_e;

  ////////////////////////////////////////////////////////////////////
  // FSM strobes to the datapath
  ////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic     cmd_ld;       // Opcode, address and count from the frame
    logic     addr_inc;
    logic     bit_clr;
    logic     bit_en;
    logic     word_dec;
    logic     out_ld_bus;   // Output register from bus read data
    logic     out_ld_err;   // Output register from error register
    logic     out_shift;
    logic     bus_strobe;
    logic     err_check;
    logic     err_clr;      // Error register clear, frame bit decides
    logic     bus_err_clr;  // Clears the master's recorded err
    logic     crc_clr;
    logic     crc_en;
    logic     crc_in_sel;   // 1 = tdi, 0 = read data
    logic     crc_shift;
    tdo_sel_e tdo_sel;
  } dbg_ctrl_t;

  // Frame decode, taken straight from the data register
  typedef struct packed {
    logic flag;     // Bit 52, also the write start bit
    logic burst;
    logic read;
    logic ireg_wr;
  } dbg_frame_t;

  // Counter flags and bus ready
  typedef struct packed {
    logic word_zero;
    logic dec_zero;   // Count minus one is zero
    logic bit_max;    // Last bit of the current word
    logic bit_32;
    logic rdy;
  } dbg_cnt_t;

endpackage

//--- logic/bus_pkg.sv
/*
  Bus definitions
  Request and response bundles of the single-clock cyc/stb bus
*/
package bus_pkg;

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_sel_t;   // Byte enables, little-endian lanes

  // Master to slave
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    bus_sel_t  sel;
    bus_addr_t adr;
    bus_data_t dat;
  } bus_req_t;

  // Slave to master
  typedef struct packed {
    logic      ack;
    logic      err;
    bus_data_t dat;
  } bus_rsp_t;

endpackage

//--- logic/dbg_crc32.sv
/*
  Serial CRC-32
  Reflected, polynomial EDB88320, preset to ones, no final inversion;
  shifts itself out LSB first after the data
*/
module dbg_crc32
  import bus_pkg::*;
(
  input  logic      tck_i,
  input  logic      rst_i,
  input  logic      data_i,
  input  logic      enable_i,
  input  logic      clear_i,
  input  logic      shift_i,
  output bus_data_t crc_o,
  output logic      serial_o
);

  localparam bus_data_t POLY = 32'hEDB88320;

  bus_data_t crc_q;
  logic      fb;  // Feedback bit

  assign fb = crc_q[0] ^ data_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= '1;
    end else if (clear_i) begin
      crc_q <= '1;
    end else if (enable_i) begin
      crc_q <= {1'b0, crc_q[31:1]} ^ (fb ? POLY : '0);
    end else if (shift_i) begin
      crc_q <= {1'b0, crc_q[31:1]};  // Output shift, zero fill
    end
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];

endmodule

//--- logic/dbg_bus_master.sv
/*
  Bus master
  Runs one cyc/stb transaction per strobe with byte-lane steering
  and records ready and a sticky error
*/
module dbg_bus_master
  import dbg_pkg::*;
  import bus_pkg::*;
(
  input  logic        tck_i,
  input  logic        rst_i,
  input  logic        err_clr_i,
  input  logic        strobe_i,
  input  logic        rd_wrn_i,
  input  size_bytes_t size_i,
  input  bus_addr_t   addr_i,
  input  bus_data_t   data_i,
  output bus_data_t   data_o,
  output logic        rdy_o,
  output logic        err_o,
  output bus_req_t    bus_req_o,
  input  bus_rsp_t    bus_rsp_i
);

  bus_sel_t    sel_d;
  bus_data_t   wdat_d;
  bus_data_t   rdat_sh;  // Read data moved down from its lane
  size_bytes_t size_q;
  bus_addr_t   adr_q;
  bus_sel_t    sel_q;
  bus_data_t   wdat_q;
  logic        we_q;
  logic        cyc_q;
  logic        start;
  logic        done;

  assign start = strobe_i & ~cyc_q;
  assign done  = cyc_q & (bus_rsp_i.ack | bus_rsp_i.err);

  // Lanes; write data sits in the top bytes and is replicated
  always_comb begin
    case (size_i)
      3'd1: begin
        sel_d  = 4'b0001 << addr_i[1:0];
        wdat_d = {4{data_i[31:24]}};
      end
      3'd2: begin
        sel_d  = addr_i[1] ? 4'b1100 : 4'b0011;
        wdat_d = {2{data_i[31:16]}};
      end
      default: begin
        sel_d  = 4'b1111;
        wdat_d = data_i;
      end
    endcase
  end

  assign rdat_sh = bus_rsp_i.dat >> {adr_q[1:0], 3'b000};

  // Request and read payload
  always_ff @(posedge tck_i) begin
    if (start) begin
      adr_q  <= addr_i;
      sel_q  <= sel_d;
      wdat_q <= wdat_d;
      we_q   <= ~rd_wrn_i;
      size_q <= size_i;
    end
    if (done && !we_q) begin
      case (size_q)
        3'd1:    data_o <= {24'h0, rdat_sh[7:0]};
        3'd2:    data_o <= {16'h0, rdat_sh[15:0]};
        default: data_o <= rdat_sh;
      endcase
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      cyc_q <= 1'b0;
      rdy_o <= 1'b1;
      err_o <= 1'b0;
    end else begin
      if (start) begin
        cyc_q <= 1'b1;
        rdy_o <= 1'b0;
      end else if (done) begin
        cyc_q <= 1'b0;
        rdy_o <= 1'b1;
      end
      if (err_clr_i) err_o <= 1'b0;
      else if (done && bus_rsp_i.err) err_o <= 1'b1;  // Sticky
    end
  end

  assign bus_req_o = '{
    cyc: cyc_q,
    stb: cyc_q,
    we:  we_q,
    sel: sel_q,
    adr: adr_q,
    dat: wdat_q
  };

endmodule

//--- logic/dbg_burst_fsm.sv
/*
  Burst control FSM
  Sequences burst reads and writes from the TAP strobes and raises
  the datapath strobes from the next-state decision
*/
module dbg_burst_fsm
  import dbg_pkg::*;
(
  input  logic       tck_i,
  input  logic       rst_i,
  input  logic       capture_dr_i,
  input  logic       shift_dr_i,
  input  logic       update_dr_i,
  input  logic       module_select_i,
  input  dbg_frame_t frame_i,
  input  dbg_cnt_t   cnt_i,
  output dbg_ctrl_t  ctrl_o,
  output logic       top_inhibit_o
);

  typedef enum logic [3:0] {
    IDLE, RBEGIN, RREADY, RSTATUS, RBURST, RCRC,
    WREADY, WWAIT, WBURST, WCRC, WMATCH
  } state_e;

  state_e state_q;
  state_e state_n;
  logic   module_cmd;  // Frame addressed to this module
  logic   rd_load;     // Next read word goes to the output register

  assign module_cmd = module_select_i & ~frame_i.flag;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    state_n = state_q;
    case (state_q)
      IDLE: begin
        if (module_cmd && update_dr_i && frame_i.burst) begin
          state_n = frame_i.read ? RBEGIN : WREADY;
        end
      end
      RBEGIN: state_n = cnt_i.word_zero ? IDLE : RREADY;  // Zero count is dropped
      RREADY: begin
        if (module_select_i && capture_dr_i) state_n = RSTATUS;
      end
      RSTATUS: begin
        if (update_dr_i) state_n = IDLE;
        else if (cnt_i.rdy) state_n = RBURST;  // First data word is in
      end
      RBURST: begin
        if (update_dr_i) state_n = IDLE;
        else if (cnt_i.bit_max && cnt_i.word_zero) state_n = RCRC;
      end
      RCRC: begin
        if (update_dr_i) state_n = IDLE;  // Recovery state too
      end
      WREADY: begin
        if (cnt_i.word_zero) state_n = IDLE;
        else if (module_select_i && capture_dr_i) state_n = WWAIT;
      end
      WWAIT: begin
        if (update_dr_i) state_n = IDLE;
        else if (module_select_i && frame_i.flag) state_n = WBURST;  // Start bit
      end
      WBURST: begin
        if (update_dr_i) state_n = IDLE;
        else if (cnt_i.bit_max && cnt_i.word_zero) state_n = WCRC;
      end
      WCRC: begin
        if (update_dr_i) state_n = IDLE;
        else if (cnt_i.bit_32) state_n = WMATCH;
      end
      WMATCH: begin
        if (update_dr_i) state_n = IDLE;
      end
      default: state_n = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Datapath strobes
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    ctrl_o  = '0;  // TDO shows ready by default
    rd_load = 1'b0;
    case (state_q)
      IDLE: begin
        // Error register access
        if (module_select_i && shift_dr_i) begin
          ctrl_o.out_shift = 1'b1;
          ctrl_o.tdo_sel   = DATA;
        end
        if (module_select_i && capture_dr_i) ctrl_o.out_ld_err = 1'b1;
        if (module_cmd && update_dr_i && frame_i.ireg_wr) ctrl_o.err_clr = 1'b1;
        // New burst command
        if (state_n != IDLE) begin
          ctrl_o.cmd_ld      = 1'b1;
          ctrl_o.bit_clr     = 1'b1;
          ctrl_o.crc_clr     = 1'b1;
          ctrl_o.bus_err_clr = 1'b1;
        end
      end
      RBEGIN: begin
        if (!cnt_i.word_zero) begin  // First read of the burst
          ctrl_o.bus_strobe = 1'b1;
          ctrl_o.addr_inc   = 1'b1;
        end
      end
      RSTATUS: rd_load = (state_n == RBURST);
      RBURST: begin
        ctrl_o.tdo_sel   = DATA;
        ctrl_o.out_shift = 1'b1;
        ctrl_o.bit_en    = 1'b1;
        ctrl_o.crc_en    = 1'b1;  // CRC takes the bit leaving on TDO
        rd_load          = cnt_i.bit_max && !cnt_i.word_zero;
      end
      RCRC: begin
        ctrl_o.tdo_sel   = CRC_OUT;
        ctrl_o.crc_shift = 1'b1;
      end
      WWAIT: begin
        ctrl_o.tdo_sel = DATA;
        if (state_n == WBURST) begin
          // First data bit is already on tdi
          ctrl_o.bit_en     = 1'b1;
          ctrl_o.word_dec   = 1'b1;
          ctrl_o.crc_en     = 1'b1;
          ctrl_o.crc_in_sel = 1'b1;
        end
      end
      WBURST: begin
        ctrl_o.tdo_sel    = DATA;
        ctrl_o.bit_en     = 1'b1;
        ctrl_o.crc_en     = 1'b1;
        ctrl_o.crc_in_sel = 1'b1;
        if (cnt_i.bit_max) begin
          // Word complete, previous bus write must be done by now
          ctrl_o.err_check  = 1'b1;
          ctrl_o.bit_clr    = 1'b1;
          ctrl_o.bus_strobe = 1'b1;
          ctrl_o.addr_inc   = 1'b1;
          ctrl_o.word_dec   = 1'b1;
        end
      end
      WCRC: begin
        ctrl_o.bit_en = 1'b1;
        if (state_n == WMATCH) ctrl_o.tdo_sel = CRC_MATCH;
      end
      WMATCH: begin
        ctrl_o.tdo_sel   = CRC_MATCH;
        ctrl_o.err_check = (state_n == IDLE);  // Last write of the burst
      end
      default: ;
    endcase

    // Load a read word and start the next bus read
    if (rd_load) begin
      ctrl_o.err_check  = 1'b1;
      ctrl_o.out_ld_bus = 1'b1;
      ctrl_o.bit_clr    = 1'b1;
      ctrl_o.word_dec   = 1'b1;
      if (!cnt_i.dec_zero && !cnt_i.word_zero) begin
        ctrl_o.bus_strobe = 1'b1;
        ctrl_o.addr_inc   = 1'b1;
      end
    end
  end

  // Top level kept off the chain while a burst is shifting
  assign top_inhibit_o = !(state_q inside {IDLE, RBEGIN, RREADY, WREADY});

endmodule

//--- logic/dbg_burst_datapath.sv
/*
  Burst datapath
  Frame decode, opcode latch, address/word/bit counters, output shift
  register, bus error register and the TDO source select
*/
module dbg_burst_datapath
  import dbg_pkg::*;
  import bus_pkg::*;
(
  input  logic        tck_i,
  input  logic        rst_i,
  input  logic        tdi_i,
  input  dr_word_t    data_register_i,
  input  dbg_ctrl_t   ctrl_i,
  output dbg_frame_t  frame_o,
  output dbg_cnt_t    cnt_o,
  // Bus master
  output logic        bus_strobe_o,
  output bus_addr_t   bus_addr_o,
  output bus_data_t   bus_wdata_o,
  output size_bytes_t bus_size_o,
  output logic        bus_rd_wrn_o,
  output logic        bus_err_clr_o,
  input  logic        bus_rdy_i,
  input  logic        bus_err_i,
  input  bus_data_t   bus_rdata_i,
  // CRC
  output logic        crc_data_o,
  output logic        crc_en_o,
  output logic        crc_clr_o,
  output logic        crc_shift_o,
  input  bus_data_t   crc_i,
  input  logic        crc_serial_i,
  output logic        module_tdo_o
);

  dbg_op_e     op_in;       // Opcode field of the incoming frame
  dbg_op_e     op_q;
  bus_addr_t   addr_q;
  word_cnt_t   word_q;
  word_cnt_t   word_dec;
  bit_cnt_t    bit_q;
  bit_cnt_t    size_bits;   // Word size minus one
  size_bytes_t size_bytes;
  logic [32:0] out_q;       // Wide enough for the error register
  logic [32:0] err_q;       // {address, error bit}
  logic        crc_match;

  ////////////////////////////////////////////////////////////////////
  // Frame decode
  ////////////////////////////////////////////////////////////////////
  assign op_in   = dbg_op_e'(data_register_i[OP_MSB:OP_LSB]);
  assign frame_o = '{
    flag:    data_register_i[FLAG_BIT],
    burst:   ~op_in[3] & (op_in[0] | op_in[1]),
    read:    ~op_in[3] & (op_in[0] | op_in[1]) & op_in[2],
    ireg_wr: (op_in == IREG_WR)
  };

  // Word size from the latched opcode
  always_comb begin
    case (op_q)
      BWRITE8, BREAD8: begin
        size_bits  = 6'd7;
        size_bytes = 3'd1;
      end
      BWRITE16, BREAD16: begin
        size_bits  = 6'd15;
        size_bytes = 3'd2;
      end
      default: begin
        size_bits  = 6'd31;
        size_bytes = 3'd4;
      end
    endcase
  end

  // Opcode, address and counters
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      op_q   <= dbg_op_e'('0);
      addr_q <= '0;
      word_q <= '0;
      bit_q  <= '0;
    end else begin
      if (ctrl_i.cmd_ld) begin
        op_q   <= op_in;
        addr_q <= data_register_i[ADDR_MSB:ADDR_LSB];
        word_q <= data_register_i[CNT_MSB:CNT_LSB];
      end else begin
        if (ctrl_i.addr_inc) addr_q <= addr_q + 32'(size_bytes);
        if (ctrl_i.word_dec) word_q <= word_dec;
      end
      if (ctrl_i.bit_clr) bit_q <= '0;  // Wins over the count
      else if (ctrl_i.bit_en) bit_q <= bit_q + 6'd1;
    end
  end

  assign word_dec = word_q - 16'd1;
  assign cnt_o    = '{
    word_zero: (word_q == '0),
    dec_zero:  (word_dec == '0),
    bit_max:   (bit_q == size_bits),
    bit_32:    (bit_q == 6'd32),
    rdy:       bus_rdy_i
  };

  // Output shift register, LSB on TDO
  always_ff @(posedge tck_i) begin
    if (ctrl_i.out_ld_bus) out_q <= {1'b0, bus_rdata_i};
    else if (ctrl_i.out_ld_err) out_q <= err_q;
    else if (ctrl_i.out_shift) out_q <= {1'b0, out_q[32:1]};
  end

  ////////////////////////////////////////////////////////////////////
  // Error register, address frozen once the error bit is set
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      err_q <= '0;
    end else if (ctrl_i.err_clr) begin
      if (data_register_i[ERR_CLEAR_BIT]) err_q[0] <= 1'b0;
    end else if (!err_q[0]) begin
      if (ctrl_i.err_check && (bus_err_i || !bus_rdy_i)) begin
        err_q[0] <= 1'b1;  // Bus error or write overrun
      end else if (ctrl_i.bus_strobe) begin
        err_q[32:1] <= addr_q;
      end
    end
  end

  // Bus master side
  assign bus_strobe_o  = ctrl_i.bus_strobe;
  assign bus_addr_o    = addr_q;
  assign bus_wdata_o   = {tdi_i, data_register_i[FLAG_BIT:FLAG_BIT-30]};  // Last bit from tdi
  assign bus_size_o    = size_bytes;
  assign bus_rd_wrn_o  = op_q[2];
  assign bus_err_clr_o = ctrl_i.bus_err_clr;

  // CRC side
  assign crc_data_o  = ctrl_i.crc_in_sel ? tdi_i : out_q[0];
  assign crc_en_o    = ctrl_i.crc_en;
  assign crc_clr_o   = ctrl_i.crc_clr;
  assign crc_shift_o = ctrl_i.crc_shift;
  assign crc_match   = (data_register_i[FLAG_BIT:FLAG_BIT-31] == crc_i);

  always_comb begin
    case (ctrl_i.tdo_sel)
      STATUS:    module_tdo_o = bus_rdy_i;
      DATA:      module_tdo_o = out_q[0];
      CRC_MATCH: module_tdo_o = crc_match;
      default:   module_tdo_o = crc_serial_i;
    endcase
  end

endmodule

//--- logic/dbg_bus_module.sv
/*
  JTAG debug bus module
  Burst reads and writes on the bus from TAP commands, CRC checked
*/
module dbg_bus_module
  import dbg_pkg::*;
  import bus_pkg::*;
(
  input  logic     tck_i,
  input  logic     rst_i,
  input  logic     tdi_i,
  input  logic     capture_dr_i,
  input  logic     shift_dr_i,
  input  logic     update_dr_i,
  input  logic     module_select_i,
  input  dr_word_t data_register_i,
  output logic     module_tdo_o,
  output logic     top_inhibit_o,
  output bus_req_t bus_req_o,
  input  bus_rsp_t bus_rsp_i
);

  dbg_ctrl_t   ctrl;
  dbg_frame_t  frame;
  dbg_cnt_t    cnt;
  // Datapath to bus master
  logic        bus_strobe;
  bus_addr_t   bus_addr;
  bus_data_t   bus_wdata;
  size_bytes_t bus_size;
  logic        bus_rd_wrn;
  logic        bus_err_clr;
  logic        bus_rdy;
  logic        bus_err;
  bus_data_t   bus_rdata;
  // Datapath to CRC
  logic        crc_data;
  logic        crc_en;
  logic        crc_clr;
  logic        crc_shift;
  logic        crc_serial;
  bus_data_t   crc_word;

  dbg_burst_fsm dbg_burst_fsm_i (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .module_select_i (module_select_i),
    .frame_i         (frame),
    .cnt_i           (cnt),
    .ctrl_o          (ctrl),
    .top_inhibit_o   (top_inhibit_o)
  );

  dbg_burst_datapath dbg_burst_datapath_i (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tdi_i           (tdi_i),
    .data_register_i (data_register_i),
    .ctrl_i          (ctrl),
    .frame_o         (frame),
    .cnt_o           (cnt),
    .bus_strobe_o    (bus_strobe),
    .bus_addr_o      (bus_addr),
    .bus_wdata_o     (bus_wdata),
    .bus_size_o      (bus_size),
    .bus_rd_wrn_o    (bus_rd_wrn),
    .bus_err_clr_o   (bus_err_clr),
    .bus_rdy_i       (bus_rdy),
    .bus_err_i       (bus_err),
    .bus_rdata_i     (bus_rdata),
    .crc_data_o      (crc_data),
    .crc_en_o        (crc_en),
    .crc_clr_o       (crc_clr),
    .crc_shift_o     (crc_shift),
    .crc_i           (crc_word),
    .crc_serial_i    (crc_serial),
    .module_tdo_o    (module_tdo_o)
  );

  dbg_bus_master dbg_bus_master_i (
    .tck_i     (tck_i),
    .rst_i     (rst_i),
    .err_clr_i (bus_err_clr),
    .strobe_i  (bus_strobe),
    .rd_wrn_i  (bus_rd_wrn),
    .size_i    (bus_size),
    .addr_i    (bus_addr),
    .data_i    (bus_wdata),
    .data_o    (bus_rdata),
    .rdy_o     (bus_rdy),
    .err_o     (bus_err),
    .bus_req_o (bus_req_o),
    .bus_rsp_i (bus_rsp_i)
  );

  dbg_crc32 dbg_crc32_i (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .data_i   (crc_data),
    .enable_i (crc_en),
    .clear_i  (crc_clr),
    .shift_i  (crc_shift),
    .crc_o    (crc_word),
    .serial_o (crc_serial)
  );

endmodule

//--- verif/bus_mem_model.sv
/*
  Bus slave memory model
  Sparse word memory with 0 to 3 random wait states per access,
  and an error response for every access to one fixed address
*/
module bus_mem_model
  import bus_pkg::*;
(
  input  logic     tck_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam bus_addr_t ERR_ADDR = 32'h0000_BAD0;

  bus_data_t   mem [bus_addr_t];    // Written words, keyed by word address
  logic [31:0] seed   = 32'h7842;   // LCG state
  logic [1:0]  wait_left = 2'd0;
  logic        active = 1'b0;       // Access seen, wait states chosen

  // Linear congruential generator for the wait states
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Content of a word never written, built from every address bit
  function automatic bus_data_t fill_word(input bus_addr_t a);
    return {a[15:0], a[31:16]} ^ 32'hC3A5_5A3C;
  endfunction

  always @(posedge tck_i) begin
    bus_addr_t wa;
    bus_data_t w;
    wa = {bus_req_i.adr[31:2], 2'b00};
    bus_rsp_o.ack <= 1'b0;  // One cycle pulses
    bus_rsp_o.err <= 1'b0;
    if (bus_req_i.cyc && bus_req_i.stb && !bus_rsp_o.ack && !bus_rsp_o.err) begin
      if (!active) begin
        seed      = lcg_next(seed);
        wait_left = seed[17:16];
        active    = 1'b1;
      end
      if (wait_left != 2'd0) begin
        wait_left = wait_left - 2'd1;  // Back-pressure
      end else begin
        active = 1'b0;
        w = mem.exists(wa) ? mem[wa] : fill_word(wa);
        if (wa == ERR_ADDR) begin
          bus_rsp_o.err <= 1'b1;
        end else if (bus_req_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (bus_req_i.sel[b]) w[8*b +: 8] = bus_req_i.dat[8*b +: 8];
          end
          mem[wa] = w;
          bus_rsp_o.ack <= 1'b1;
        end else begin
          bus_rsp_o.dat <= w;
          bus_rsp_o.ack <= 1'b1;
        end
      end
    end
  end

endmodule

//--- verif/tb_dbg_bus_module.sv
/*
  Testbench for the JTAG debug bus module
  Models the TAP data register and runs directed burst, CRC and
  error register tests against a wait-state memory
*/
module tb_dbg_bus_module
  import dbg_pkg::*;
  import bus_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam bus_addr_t BASE_ADDR    = 32'h0000_0100;
  localparam int        STATUS_LIMIT = 64;  // Shift cycles allowed for read latency
  // Shifted bits of all bursts and register reads
  localparam int BURST_BITS = 2 * (4 * 32 + 32) + (4 * 8 + 32) + (4 * 16 + 32)
                              + (8 + 32) + 2 * 33;
  localparam int TIMEOUT_CYCLES = BURST_BITS * 8 + 500;

  logic      tck_i = 1'b0;
  logic      rst_i;
  logic      tdi_i;
  logic      capture_dr_i;
  logic      shift_dr_i;
  logic      update_dr_i;
  logic      module_select_i;
  dr_word_t  data_register_i;
  logic      module_tdo_o;
  logic      top_inhibit_o;
  bus_req_t  bus_req_o;
  bus_rsp_t  bus_rsp_i;

  dr_word_t    dr;              // TAP data register, tdi enters at bit 52
  logic [31:0] image [0:3];     // Burst words written at BASE_ADDR
  int          errors       = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          cycle_cnt    = 0;

  always #4 tck_i = ~tck_i;  // 8 ns period

  dbg_bus_module dbg_bus_module_i (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tdi_i           (tdi_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .module_select_i (module_select_i),
    .data_register_i (data_register_i),
    .module_tdo_o    (module_tdo_o),
    .top_inhibit_o   (top_inhibit_o),
    .bus_req_o       (bus_req_o),
    .bus_rsp_i       (bus_rsp_i)
  );

  bus_mem_model mem_i (
    .tck_i     (tck_i),
    .bus_req_i (bus_req_o),
    .bus_rsp_o (bus_rsp_i)
  );

  // Watchdog
  always @(posedge tck_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycle_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference models and helpers
  //////////////////////////////////////////////////////////////////////

  // One bit of reflected CRC-32, preset ones, no final inversion
  function automatic logic [31:0] crc32_step(input logic [31:0] c, input logic b);
    return (c[0] ^ b) ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
  endfunction

  // Little-endian word of nbits at addr from the written image
  function automatic logic [31:0] expected_read(input bus_addr_t addr, input int nbits);
    logic [31:0] w;
    int          idx;
    idx = int'((addr - BASE_ADDR) >> 2);
    w   = image[idx] >> (8 * addr[1:0]);
    if (nbits == 8) return {24'h0, w[7:0]};
    else if (nbits == 16) return {16'h0, w[15:0]};
    return w;
  endfunction

  task automatic check_value(input string what, input logic [32:0] got,
                             input logic [32:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  // One TCK cycle of the TAP, entered and left just after a rising edge
  task automatic tap_cycle(input logic cap, input logic sh, input logic upd,
                           input logic bit_in, output logic bit_out);
    data_register_i = dr;
    capture_dr_i    = cap;
    shift_dr_i      = sh;
    update_dr_i     = upd;
    tdi_i           = bit_in;
    @(negedge tck_i);
    bit_out = module_tdo_o;  // Mid-cycle sample
    @(posedge tck_i);
    if (cap) dr = '0;
    else if (sh) dr = {bit_in, dr[52:1]};
    #1;
  endtask

  // Update with a frame, then idle cycles as a real TAP walk takes
  task automatic send_frame(input dr_word_t frame);
    logic b;
    dr = frame;
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, b);
    repeat (2) tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, b);
  endtask

  task automatic send_command(input dbg_op_e op, input bus_addr_t addr,
                              input word_cnt_t count);
    send_frame({1'b0, op, addr, count});
  endtask

  //////////////////////////////////////////////////////////////////////
  // Burst and register sequences
  //////////////////////////////////////////////////////////////////////

  // 32-bit write burst of the image, returns the CRC match bit
  task automatic write_burst(input logic flip_crc, output logic match);
    logic        b;
    logic [31:0] crc;
    crc = '1;
    send_command(BWRITE32, BASE_ADDR, 16'd4);
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, b);  // Capture
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b1, b);  // Start bit
    check_value("inhibit in burst", {32'h0, top_inhibit_o}, 33'h1);
    for (int w = 0; w < 4; w++) begin
      for (int i = 0; i < 32; i++) begin
        tap_cycle(1'b0, 1'b1, 1'b0, image[w][i], b);
        crc = crc32_step(crc, image[w][i]);
      end
    end
    if (flip_crc) crc[5] = ~crc[5];
    for (int i = 0; i < 32; i++) tap_cycle(1'b0, 1'b1, 1'b0, crc[i], b);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, match);  // Match bit on TDO
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, b);      // Back to idle
    check_value("inhibit after burst", {32'h0, top_inhibit_o}, 33'h0);
  endtask

  task automatic read_burst(input dbg_op_e op, input bus_addr_t addr, input int count,
                            input int nbits, input logic check_data);
    logic        b;
    int          waited;
    logic [31:0] word;
    logic [31:0] crc;
    logic [31:0] rx_crc;
    crc    = '1;
    rx_crc = '0;
    waited = 0;
    b      = 1'b0;
    send_command(op, addr, word_cnt_t'(count));
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, b);
    b = 1'b0;
    // Status bit is ready, data follows right after it
    while (!b && waited < STATUS_LIMIT) begin
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, b);
      waited++;
    end
    if (!b) begin
      $display("Read status bit did not appear within %0d cycles at %0t",
               STATUS_LIMIT, $time);
      errors++;
    end
    for (int w = 0; w < count; w++) begin
      word = '0;
      for (int i = 0; i < nbits; i++) begin
        tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, b);
        word[i] = b;
        crc     = crc32_step(crc, b);
      end
      if (check_data) begin
        check_value("read word", {1'b0, word},
                    {1'b0, expected_read(addr + bus_addr_t'(w * nbits / 8), nbits)});
      end
    end
    for (int i = 0; i < 32; i++) begin
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, b);
      rx_crc[i] = b;
    end
    check_value("read CRC", {1'b0, rx_crc}, {1'b0, crc});
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, b);
  endtask

  // Idle capture of {address, error bit}, LSB first
  task automatic read_error_reg(output logic [32:0] val);
    logic b;
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, b);
    for (int i = 0; i < 33; i++) begin
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, b);
      val[i] = b;
    end
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, b);
  endtask

  // Zero-length burst must return to idle without a bus cycle
  task automatic zero_count_burst(input dbg_op_e op);
    logic b;
    dr = {1'b0, op, BASE_ADDR, 16'd0};
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, b);
    for (int i = 0; i < 8; i++) begin
      if (bus_req_o.cyc) begin
        $display("Bus cycle started by a zero-length burst at %0t", $time);
        errors++;
      end
      if (top_inhibit_o) begin
        $display("top_inhibit_o raised by a zero-length burst at %0t", $time);
        errors++;
      end
      tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, b);
    end
    check_value("idle ready on TDO", {32'h0, b}, 33'h1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////
  initial begin
    int          start;
    logic        match;
    logic [32:0] err_reg;
    rst_i           = 1'b1;
    tdi_i           = 1'b0;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b1;
    data_register_i = '0;
    dr              = '0;
    image[0] = 32'hDEAD_BEEF;
    image[1] = 32'h0123_4567;
    image[2] = 32'h89AB_CDEF;
    image[3] = 32'h5A5A_A5A5;
    repeat (10) @(posedge tck_i);
    #1 rst_i = 1'b0;

    start = errors;  // Reset state
    check_value("reset tdo", {32'h0, module_tdo_o}, 33'h1);
    check_value("reset inhibit", {32'h0, top_inhibit_o}, 33'h0);
    check_value("reset cyc", {32'h0, bus_req_o.cyc}, 33'h0);
    check_value("reset stb", {32'h0, bus_req_o.stb}, 33'h0);
    finish_test("reset", start);

    start = errors;
    write_burst(1'b0, match);
    check_value("CRC match bit", {32'h0, match}, 33'h1);
    for (int w = 0; w < 4; w++) begin
      check_value("memory word", {1'b0, mem_i.mem[BASE_ADDR + bus_addr_t'(4 * w)]},
                  {1'b0, image[w]});
    end
    finish_test("write32 good CRC", start);

    start = errors;
    write_burst(1'b1, match);
    check_value("CRC match bit", {32'h0, match}, 33'h0);
    finish_test("write32 bad CRC", start);

    start = errors;
    read_burst(BREAD8, BASE_ADDR, 4, 8, 1'b1);
    read_burst(BREAD16, BASE_ADDR, 4, 16, 1'b1);
    finish_test("read8 and read16", start);

    start = errors;  // Error address latched by the failing read
    read_burst(BREAD8, 32'h0000_BAD0, 1, 8, 1'b0);
    read_error_reg(err_reg);
    check_value("error register", err_reg, {32'h0000_BAD0, 1'b1});
    finish_test("bus error", start);

    start = errors;
    dr = '0;
    dr[OP_MSB:OP_LSB]  = IREG_WR;
    dr[ERR_CLEAR_BIT]  = 1'b1;
    send_frame(dr);
    read_error_reg(err_reg);
    check_value("error bit after clear", {32'h0, err_reg[0]}, 33'h0);
    finish_test("error clear", start);

    start = errors;
    zero_count_burst(BWRITE32);
    zero_count_burst(BREAD32);
    finish_test("zero count", start);

    $display("Summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
logic/dbg_pkg.sv
logic/bus_pkg.sv
logic/dbg_crc32.sv
logic/dbg_bus_master.sv
logic/dbg_burst_fsm.sv
logic/dbg_burst_datapath.sv
logic/dbg_bus_module.sv
verif/bus_mem_model.sv
verif/tb_dbg_bus_module.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the debug bus module testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_dbg_bus_module \
    --Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "TB PASSED" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
